// ==== include/soc_config.svh ====
// SoC configuration macros.
// Bus widths, memory size, GPIO widths and the address map.
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus geometry.
`define SOC_BUS_ADDR_WIDTH 32
`define SOC_BUS_DATA_WIDTH 32

// Main memory.
`define SOC_RAM_BYTES 65536

// Address map.
`define SOC_RAM_BASE   32'h0010_0000
`define SOC_GPIO_BASE  32'h8000_0000
`define SOC_TIMER_BASE 32'h8000_1000

// Each register block owns one region of this size.
`define SOC_REG_REGION_BYTES 4096

// GPIO widths.
`define SOC_GPI_WIDTH 8
`define SOC_GPO_WIDTH 16

`endif

// ==== design/soc_bus_pkg.sv ====
// Bus types shared by the decoder and the devices.
`include "soc_config.svh"

package soc_bus_pkg;

  // Address and data words on the bus.
  typedef logic [`SOC_BUS_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [`SOC_BUS_DATA_WIDTH-1:0] bus_data_t;

  // One enable per data byte.
  typedef logic [`SOC_BUS_DATA_WIDTH/8-1:0] bus_be_t;

  // Target of a decoded request.
  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE
  } bus_device_e;

endpackage

// ==== design/soc_periph_pkg.sv ====
// Register map of the peripherals.
`include "soc_config.svh"

package soc_periph_pkg;

  // Byte offset inside one register region.
  typedef logic [$clog2(`SOC_REG_REGION_BYTES)-1:0] reg_offset_t;

  // GPIO registers.
  localparam reg_offset_t GPIO_OUT_OFFSET = 'h0;
  localparam reg_offset_t GPIO_IN_OFFSET  = 'h4;

  // Timer registers.
  localparam reg_offset_t TIMER_MTIME_LO_OFFSET    = 'h0;
  localparam reg_offset_t TIMER_MTIME_HI_OFFSET    = 'h4;
  localparam reg_offset_t TIMER_MTIMECMP_LO_OFFSET = 'h8;
  localparam reg_offset_t TIMER_MTIMECMP_HI_OFFSET = 'hC;

endpackage

// ==== design/device_bus_if.sv ====
// Device bus between the address decoder and one device.
interface device_bus_if;
  import soc_bus_pkg::*;

  // Request from the decoder with addr as the offset in the device region.
  logic      req;
  logic      we;
  bus_addr_t addr;
  bus_be_t   be;
  bus_data_t wdata;

  // Response from the device one cycle after req.
  logic      rvalid;
  bus_data_t rdata;
  logic      err;

  modport decoder (output req, we, addr, be, wdata, input rvalid, rdata, err);
  modport device (input req, we, addr, be, wdata, output rvalid, rdata, err);

endinterface

// ==== design/bus_decoder.sv ====
// Address decoder for the single bus host.
// Steers requests to RAM, GPIO or timer and returns the response.
`include "soc_config.svh"

module bus_decoder (
  input  logic                   clk_sys_i,
  input  logic                   reset_i,
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  soc_bus_pkg::bus_addr_t host_addr_i,
  input  soc_bus_pkg::bus_be_t   host_be_i,
  input  soc_bus_pkg::bus_data_t host_wdata_i,
  output logic                   host_rvalid_o,
  output soc_bus_pkg::bus_data_t host_rdata_o,
  output logic                   host_err_o,
  device_bus_if.decoder          ram_bus,
  device_bus_if.decoder          gpio_bus,
  device_bus_if.decoder          timer_bus
);
  import soc_bus_pkg::*;

  localparam bus_addr_t RamMask = bus_addr_t'(`SOC_RAM_BYTES - 1);
  localparam bus_addr_t RegMask = bus_addr_t'(`SOC_REG_REGION_BYTES - 1);

  bus_device_e dev_sel;
  bus_device_e sel_q;
  logic        none_pending_q;

  ///////////////////////////////
  // Request decode
  ///////////////////////////////

  always_comb begin
    dev_sel = DEV_NONE;
    if ((host_addr_i & ~RamMask) == `SOC_RAM_BASE) begin
      dev_sel = DEV_RAM;
    end else if ((host_addr_i & ~RegMask) == `SOC_GPIO_BASE) begin
      dev_sel = DEV_GPIO;
    end else if ((host_addr_i & ~RegMask) == `SOC_TIMER_BASE) begin
      dev_sel = DEV_TIMER;
    end
  end

  // Strobe only the selected device.
  assign ram_bus.req   = host_req_i && (dev_sel == DEV_RAM);
  assign gpio_bus.req  = host_req_i && (dev_sel == DEV_GPIO);
  assign timer_bus.req = host_req_i && (dev_sel == DEV_TIMER);

  // Offsets within each region.
  assign ram_bus.addr   = host_addr_i & RamMask;
  assign gpio_bus.addr  = host_addr_i & RegMask;
  assign timer_bus.addr = host_addr_i & RegMask;

  assign ram_bus.we     = host_we_i;
  assign ram_bus.be     = host_be_i;
  assign ram_bus.wdata  = host_wdata_i;
  assign gpio_bus.we    = host_we_i;
  assign gpio_bus.be    = host_be_i;
  assign gpio_bus.wdata = host_wdata_i;
  assign timer_bus.we    = host_we_i;
  assign timer_bus.be    = host_be_i;
  assign timer_bus.wdata = host_wdata_i;

  ///////////////////////////////
  // Response return
  ///////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      sel_q          <= DEV_NONE;
      none_pending_q <= 1'b0;
    end else begin
      sel_q          <= dev_sel;
      none_pending_q <= host_req_i && (dev_sel == DEV_NONE);
    end
  end

  // Unmapped accesses answer with an error and zero data.
  always_comb begin
    case (sel_q)
      DEV_RAM: begin
        host_rvalid_o = ram_bus.rvalid;
        host_rdata_o  = ram_bus.rdata;
        host_err_o    = ram_bus.err;
      end
      DEV_GPIO: begin
        host_rvalid_o = gpio_bus.rvalid;
        host_rdata_o  = gpio_bus.rdata;
        host_err_o    = gpio_bus.err;
      end
      DEV_TIMER: begin
        host_rvalid_o = timer_bus.rvalid;
        host_rdata_o  = timer_bus.rdata;
        host_err_o    = timer_bus.err;
      end
      default: begin
        host_rvalid_o = none_pending_q;
        host_rdata_o  = '0;
        host_err_o    = none_pending_q;
      end
    endcase
  end

endmodule

// ==== design/ram_sp.sv ====
// Single-port RAM with byte enables and one-cycle read latency.
`include "soc_config.svh"

module ram_sp (
  input logic          clk_sys_i,
  device_bus_if.device bus
);
  import soc_bus_pkg::*;

  localparam int unsigned Words    = `SOC_RAM_BYTES / 4;
  localparam int unsigned AddrBits = $clog2(Words);

  bus_data_t             mem [Words];
  logic [AddrBits-1:0]   word_idx;
  logic                  rvalid_q;
  bus_data_t             rdata_q;

  // Word index from the byte offset.
  assign word_idx = bus.addr[AddrBits+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.be[b]) begin
          mem[word_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Writes answer with zero data.
  always_ff @(posedge clk_sys_i) begin
    rvalid_q <= bus.req;
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : mem[word_idx];
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

// ==== design/gpio.sv ====
// GPIO block with a byte-writable output register
// and a synchronized input register.
`include "soc_config.svh"

module gpio (
  input  logic                      clk_sys_i,
  input  logic                      reset_i,
  device_bus_if.device              bus,
  input  logic [`SOC_GPI_WIDTH-1:0] gp_i,
  output logic [`SOC_GPO_WIDTH-1:0] gp_o
);
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  reg_offset_t               offset;
  logic [`SOC_GPI_WIDTH-1:0] gpi_meta_q;
  logic [`SOC_GPI_WIDTH-1:0] gpi_sync_q;
  logic                      wr_out;
  logic                      rvalid_q;
  logic                      err_q;
  bus_data_t                 rdata_q;

  assign offset = reg_offset_t'(bus.addr);
  assign wr_out = bus.req && bus.we && (offset == GPIO_OUT_OFFSET);

  // Two-flop input synchronizer.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  // Output bits follow their byte enable.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      gp_o <= '0;
    end else if (wr_out) begin
      for (int i = 0; i < `SOC_GPO_WIDTH; i++) begin
        if (bus.be[i/8]) begin
          gp_o[i] <= bus.wdata[i];
        end
      end
    end
  end

  ///////////////////////////////
  // Response
  ///////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && !(offset == GPIO_OUT_OFFSET ||
                               (offset == GPIO_IN_OFFSET && !bus.we));
    end
  end

  // Input register is read-only.
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      rdata_q <= '0;
      if (!bus.we && offset == GPIO_OUT_OFFSET) begin
        rdata_q <= bus_data_t'(gp_o);
      end else if (!bus.we && offset == GPIO_IN_OFFSET) begin
        rdata_q <= bus_data_t'(gpi_sync_q);
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule

// ==== design/timer.sv ====
// Machine timer with 64-bit mtime and mtimecmp registers.
// Raises a level interrupt once mtime reaches mtimecmp.
module timer (
  input  logic         clk_sys_i,
  input  logic         reset_i,
  device_bus_if.device bus,
  output logic         timer_irq_o
);
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  reg_offset_t offset;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        wr;
  logic        hit;
  bus_data_t   rd_word;
  logic        rvalid_q;
  logic        err_q;
  bus_data_t   rdata_q;

  assign offset = reg_offset_t'(bus.addr);
  assign wr     = bus.req && bus.we;

  ///////////////////////////////
  // Register read mux
  ///////////////////////////////

  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    case (offset)
      TIMER_MTIME_LO_OFFSET:    rd_word = mtime_q[31:0];
      TIMER_MTIME_HI_OFFSET:    rd_word = mtime_q[63:32];
      TIMER_MTIMECMP_LO_OFFSET: rd_word = mtimecmp_q[31:0];
      TIMER_MTIMECMP_HI_OFFSET: rd_word = mtimecmp_q[63:32];
      default:                  hit     = 1'b0;
    endcase
  end

  // Counter runs every cycle and a write replaces one word.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      if (wr) begin
        case (offset)
          TIMER_MTIME_LO_OFFSET:    mtime_q[31:0]     <= bus.wdata;
          TIMER_MTIME_HI_OFFSET:    mtime_q[63:32]    <= bus.wdata;
          TIMER_MTIMECMP_LO_OFFSET: mtimecmp_q[31:0]  <= bus.wdata;
          TIMER_MTIMECMP_HI_OFFSET: mtimecmp_q[63:32] <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  // Interrupt level follows the counters by one cycle.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  ///////////////////////////////
  // Response
  ///////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      err_q    <= bus.req && !hit;
    end
  end

  // Zero data on writes and errors.
  always_ff @(posedge clk_sys_i) begin
    if (bus.req) begin
      rdata_q <= (bus.we || !hit) ? '0 : rd_word;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule

// ==== design/soc_system.sv ====
// SoC top level with the bus decoder and the RAM, GPIO and timer
// devices behind a single host request port.
`include "soc_config.svh"

module soc_system (
  input  logic                      clk_sys_i,
  input  logic                      reset_i,

  // Host bus.
  input  logic                      host_req_i,
  input  logic                      host_we_i,
  input  soc_bus_pkg::bus_addr_t    host_addr_i,
  input  soc_bus_pkg::bus_be_t      host_be_i,
  input  soc_bus_pkg::bus_data_t    host_wdata_i,
  output logic                      host_rvalid_o,
  output soc_bus_pkg::bus_data_t    host_rdata_o,
  output logic                      host_err_o,

  // Pins.
  input  logic [`SOC_GPI_WIDTH-1:0] gp_i,
  output logic [`SOC_GPO_WIDTH-1:0] gp_o,
  output logic                      timer_irq_o
);

  // One device bus per device.
  device_bus_if ram_bus ();
  device_bus_if gpio_bus ();
  device_bus_if timer_bus ();

  bus_decoder u_decoder (
    .clk_sys_i    (clk_sys_i),
    .reset_i      (reset_i),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .ram_bus      (ram_bus),
    .gpio_bus     (gpio_bus),
    .timer_bus    (timer_bus)
  );

  ram_sp u_ram (
    .clk_sys_i(clk_sys_i),
    .bus      (ram_bus)
  );

  gpio u_gpio (
    .clk_sys_i(clk_sys_i),
    .reset_i  (reset_i),
    .bus      (gpio_bus),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .reset_i    (reset_i),
    .bus        (timer_bus),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// ==== tb/tb_soc_system.sv ====
// Testbench for the SoC top level.
// Random bus traffic to RAM, GPIO and timer, checked against a model.
`include "soc_config.svh"

module tb_soc_system;
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  localparam int RespTimeout   = 20;
  localparam int IrqTimeout    = 400;
  localparam int MtimeRetries  = 4;
  localparam int RamWrites     = 200;
  localparam int GpioWrites    = 20;
  localparam int GpiTrials     = 8;
  localparam int UnmappedCount = 20;
  localparam int BadOffsets    = 10;
  localparam int CounterReads  = 10;
  localparam int B2BCount      = 8;

  localparam bus_addr_t GpioOutAddr = `SOC_GPIO_BASE + bus_addr_t'(GPIO_OUT_OFFSET);
  localparam bus_addr_t GpioInAddr  = `SOC_GPIO_BASE + bus_addr_t'(GPIO_IN_OFFSET);
  localparam bus_addr_t MtimeLoAddr = `SOC_TIMER_BASE + bus_addr_t'(TIMER_MTIME_LO_OFFSET);
  localparam bus_addr_t MtimeHiAddr = `SOC_TIMER_BASE + bus_addr_t'(TIMER_MTIME_HI_OFFSET);
  localparam bus_addr_t CmpLoAddr   = `SOC_TIMER_BASE + bus_addr_t'(TIMER_MTIMECMP_LO_OFFSET);
  localparam bus_addr_t CmpHiAddr   = `SOC_TIMER_BASE + bus_addr_t'(TIMER_MTIMECMP_HI_OFFSET);

  logic                      clk_sys = 1'b0;
  logic                      reset;
  logic                      host_req;
  logic                      host_we;
  bus_addr_t                 host_addr;
  bus_be_t                   host_be;
  bus_data_t                 host_wdata;
  logic                      host_rvalid;
  bus_data_t                 host_rdata;
  logic                      host_err;
  logic [`SOC_GPI_WIDTH-1:0] gp_in;
  logic [`SOC_GPO_WIDTH-1:0] gp_out;
  logic                      timer_irq;

  // Reference model state.
  logic [7:0]                ram_model [bus_addr_t];
  logic [`SOC_GPO_WIDTH-1:0] gp_model;
  logic [63:0]               cmp_model;

  integer seed;
  int     mismatches;
  int     timeouts;

  always #5 clk_sys = ~clk_sys;

  soc_system dut (
    .clk_sys_i    (clk_sys),
    .reset_i      (reset),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_be_i    (host_be),
    .host_wdata_i (host_wdata),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  ///////////////////////////////
  // Helpers
  ///////////////////////////////

  function automatic bus_data_t rand32();
    return $random(seed);
  endfunction

  // Word aligned address in a 16 word window.
  function automatic bus_addr_t random_ram_addr();
    bus_data_t r;
    r = rand32();
    return `SOC_RAM_BASE + {26'h0, r[3:0], 2'b00};
  endfunction

  function automatic bus_data_t ram_word(input bus_addr_t addr);
    bus_data_t word;
    word = '0;
    for (int b = 0; b < 4; b++) begin
      if (ram_model.exists(addr + b)) begin
        word[b*8 +: 8] = ram_model[addr + b];
      end
    end
    return word;
  endfunction

  // Bytes never written are not compared.
  function automatic bus_data_t ram_mask(input bus_addr_t addr);
    bus_data_t mask;
    mask = '0;
    for (int b = 0; b < 4; b++) begin
      if (ram_model.exists(addr + b)) begin
        mask[b*8 +: 8] = 8'hff;
      end
    end
    return mask;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at time %0t: %s", $time, msg);
  endtask

  task automatic report_and_finish();
    $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // One request, then wait for its response.
  task automatic bus_access(input logic we, input bus_addr_t addr, input bus_be_t be,
                            input bus_data_t wdata, output bus_data_t rdata,
                            output logic err);
    int cycles;
    @(posedge clk_sys);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_be    <= be;
    host_wdata <= wdata;
    @(posedge clk_sys);
    host_req <= 1'b0;
    cycles = 0;
    @(negedge clk_sys);
    while (!host_rvalid && cycles < RespTimeout) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (!host_rvalid) begin
      $display("Timeout: no response to the access at address %h.", addr);
      timeouts++;
    end
    rdata = host_rdata;
    err   = host_err;
  endtask

  task automatic write_word(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata);
    bus_data_t rdata;
    logic      err;
    bus_access(1'b1, addr, be, wdata, rdata, err);
    if (err || rdata != '0) begin
      report_mismatch($sformatf("write to %h: err %b data %h", addr, err, rdata));
    end
  endtask

  task automatic read_word(input bus_addr_t addr, output bus_data_t rdata);
    logic err;
    bus_access(1'b0, addr, '1, '0, rdata, err);
    if (err) begin
      report_mismatch($sformatf("read of %h flagged an error", addr));
    end
  endtask

  task automatic check_ram(input bus_addr_t addr, input bus_data_t rdata);
    bus_data_t exp_data;
    bus_data_t mask;
    exp_data = ram_word(addr);
    mask     = ram_mask(addr);
    if (((rdata ^ exp_data) & mask) != '0) begin
      report_mismatch($sformatf("RAM %h: got %h, expected %h under mask %h",
                                addr, rdata, exp_data, mask));
    end
  endtask

  // High word read twice so a carry between reads is caught.
  task automatic read_mtime(output logic [63:0] value);
    bus_data_t hi;
    bus_data_t lo;
    bus_data_t hi2;
    int        tries;
    logic      done;
    tries = 0;
    done  = 1'b0;
    value = '0;
    while (!done && tries < MtimeRetries) begin
      read_word(MtimeHiAddr, hi);
      read_word(MtimeLoAddr, lo);
      read_word(MtimeHiAddr, hi2);
      if (hi == hi2) begin
        value = {hi, lo};
        done  = 1'b1;
      end
      tries++;
    end
    if (!done) begin
      $display("Timeout: the mtime high word kept changing between reads.");
      timeouts++;
    end
  endtask

  task automatic expect_error(input bus_addr_t addr, input logic we, input string what);
    bus_data_t wdata;
    bus_data_t r;
    bus_data_t rdata;
    logic      err;
    wdata = rand32();
    r     = rand32();
    bus_access(we, addr, r[3:0], wdata, rdata, err);
    if (!err || rdata != '0) begin
      report_mismatch($sformatf("%s at %h: err %b data %h", what, addr, err, rdata));
    end
  endtask

  ///////////////////////////////
  // Tests
  ///////////////////////////////

  task automatic test_ram();
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t rdata;
    bus_data_t r;
    bus_be_t   be;
    for (int i = 0; i < RamWrites; i++) begin
      addr  = random_ram_addr();
      wdata = rand32();
      r     = rand32();
      be    = r[3:0];
      write_word(addr, be, wdata);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ram_model[addr + b] = wdata[b*8 +: 8];
        end
      end
      if (r[4]) begin
        addr = random_ram_addr();
        read_word(addr, rdata);
        check_ram(addr, rdata);
      end
    end
  endtask

  task automatic test_gpio();
    bus_data_t                 wdata;
    bus_data_t                 rdata;
    bus_data_t                 r;
    bus_be_t                   be;
    logic [`SOC_GPI_WIDTH-1:0] gpi_val;
    for (int i = 0; i < GpioWrites; i++) begin
      wdata = rand32();
      r     = rand32();
      be    = r[3:0];
      write_word(GpioOutAddr, be, wdata);
      for (int b = 0; b < `SOC_GPO_WIDTH / 8; b++) begin
        if (be[b]) begin
          gp_model[b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      if (gp_out != gp_model) begin
        report_mismatch($sformatf("gp_o is %h, expected %h", gp_out, gp_model));
      end
      read_word(GpioOutAddr, rdata);
      if (rdata != bus_data_t'(gp_model)) begin
        report_mismatch($sformatf("GPIO out readback %h, expected %h", rdata, gp_model));
      end
    end
    for (int i = 0; i < GpiTrials; i++) begin
      r       = rand32();
      gpi_val = r[`SOC_GPI_WIDTH-1:0];
      @(posedge clk_sys);
      gp_in <= gpi_val;
      repeat (3) @(posedge clk_sys);
      read_word(GpioInAddr, rdata);
      if (rdata != bus_data_t'(gpi_val)) begin
        report_mismatch($sformatf("GPIO in read %h, expected %h", rdata, gpi_val));
      end
    end
  endtask

  task automatic test_errors();
    bus_addr_t   addr;
    bus_data_t   r;
    bus_data_t   rdata;
    reg_offset_t off;
    for (int i = 0; i < UnmappedCount; i++) begin
      addr = rand32();
      // Flipping bit 30 moves any mapped address out of the map.
      if ((addr & ~bus_addr_t'(`SOC_RAM_BYTES - 1)) == `SOC_RAM_BASE ||
          (addr & ~bus_addr_t'(2 * `SOC_REG_REGION_BYTES - 1)) == `SOC_GPIO_BASE) begin
        addr = addr ^ 32'h4000_0000;
      end
      r = rand32();
      expect_error(addr, r[0], "unmapped access");
    end
    for (int i = 0; i < BadOffsets; i++) begin
      r   = rand32();
      off = r[11:0];
      if (off == GPIO_OUT_OFFSET || off == GPIO_IN_OFFSET) begin
        off = off | 12'h8;
      end
      expect_error(`SOC_GPIO_BASE + bus_addr_t'(off), r[12], "unknown GPIO offset");
      r   = rand32();
      off = r[11:0];
      if (off[11:4] == '0 && off[1:0] == 2'b00) begin
        off = off | 12'h10;
      end
      expect_error(`SOC_TIMER_BASE + bus_addr_t'(off), r[12], "unknown timer offset");
    end
    for (int i = 0; i < 5; i++) begin
      expect_error(GpioInAddr, 1'b1, "write to GPIO input");
    end

    // Nothing above may have changed device state.
    if (gp_out != gp_model) begin
      report_mismatch($sformatf("gp_o changed to %h, expected %h", gp_out, gp_model));
    end
    read_word(CmpLoAddr, rdata);
    if (rdata != cmp_model[31:0]) begin
      report_mismatch($sformatf("mtimecmp low changed to %h", rdata));
    end
    read_word(CmpHiAddr, rdata);
    if (rdata != cmp_model[63:32]) begin
      report_mismatch($sformatf("mtimecmp high changed to %h", rdata));
    end
    for (int i = 0; i < 4; i++) begin
      addr = random_ram_addr();
      read_word(addr, rdata);
      check_ram(addr, rdata);
    end
  endtask

  task automatic test_counter();
    logic [63:0] prev;
    logic [63:0] now;
    read_mtime(prev);
    for (int i = 0; i < CounterReads; i++) begin
      read_mtime(now);
      if (now <= prev) begin
        report_mismatch($sformatf("mtime %h not above previous %h", now, prev));
      end
      prev = now;
    end
  endtask

  task automatic test_irq();
    logic [63:0] now;
    logic [63:0] cmp;
    logic [63:0] later;
    bus_data_t   r;
    int          cycles;
    read_mtime(now);
    r   = rand32();
    cmp = now + 64'(r % 181) + 64'd20;
    write_word(CmpHiAddr, '1, cmp[63:32]);
    write_word(CmpLoAddr, '1, cmp[31:0]);
    cmp_model = cmp;
    cycles = 0;
    while (!timer_irq && cycles < IrqTimeout) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (!timer_irq) begin
      $display("Timeout: the timer interrupt did not rise.");
      timeouts++;
    end
    read_mtime(later);
    if (later < cmp) begin
      report_mismatch($sformatf("interrupt high with mtime %h below compare %h", later, cmp));
    end
    write_word(CmpHiAddr, '1, 32'hffff_ffff);
    write_word(CmpLoAddr, '1, 32'hffff_ffff);
    cmp_model = '1;
    cycles = 0;
    while (timer_irq && cycles < IrqTimeout) begin
      @(negedge clk_sys);
      cycles++;
    end
    if (timer_irq) begin
      $display("Timeout: the timer interrupt did not fall.");
      timeouts++;
    end
  endtask

  // Reads on consecutive cycles alternating between RAM and GPIO.
  task automatic test_back_to_back();
    bus_addr_t addr_q [B2BCount];
    bus_data_t exp_q  [B2BCount];
    bus_data_t mask_q [B2BCount];
    for (int i = 0; i < B2BCount; i++) begin
      if (i % 2 == 0) begin
        addr_q[i] = random_ram_addr();
        exp_q[i]  = ram_word(addr_q[i]);
        mask_q[i] = ram_mask(addr_q[i]);
      end else begin
        addr_q[i] = GpioOutAddr;
        exp_q[i]  = bus_data_t'(gp_model);
        mask_q[i] = '1;
      end
    end
    for (int i = 0; i <= B2BCount; i++) begin
      @(posedge clk_sys);
      if (i < B2BCount) begin
        host_req   <= 1'b1;
        host_we    <= 1'b0;
        host_addr  <= addr_q[i];
        host_be    <= '1;
        host_wdata <= '0;
      end else begin
        host_req <= 1'b0;
      end
      @(negedge clk_sys);
      if (i == 0) begin
        if (host_rvalid) begin
          report_mismatch("rvalid high before the first back-to-back request");
        end
      end else begin
        if (!host_rvalid) begin
          report_mismatch($sformatf("no rvalid one cycle after request %0d", i - 1));
        end
        if (((host_rdata ^ exp_q[i-1]) & mask_q[i-1]) != '0 || host_err) begin
          report_mismatch($sformatf("request %0d at %h: got %h err %b, expected %h",
                                    i - 1, addr_q[i-1], host_rdata, host_err, exp_q[i-1]));
        end
      end
    end
    @(negedge clk_sys);
    if (host_rvalid) begin
      report_mismatch("extra rvalid after the last back-to-back request");
    end
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    seed       = 32'hdefd0194;
    mismatches = 0;
    timeouts   = 0;
    gp_model   = '0;
    cmp_model  = '1;
    reset      = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_be    = '0;
    host_wdata = '0;
    gp_in      = '0;
    repeat (3) @(posedge clk_sys);
    reset <= 1'b0;
    @(negedge clk_sys);
    if (host_rvalid || host_err || timer_irq || gp_out != '0) begin
      report_mismatch("outputs not in their reset state");
    end
    test_ram();
    test_gpio();
    test_errors();
    test_counter();
    test_irq();
    test_back_to_back();
    report_and_finish();
  end

endmodule

// ==== build.f ====
+incdir+include
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/device_bus_if.sv
design/bus_decoder.sv
design/ram_sp.sv
design/gpio.sv
design/timer.sv
design/soc_system.sv
tb/tb_soc_system.sv

// ==== Makefile ====
# Verilator build and run of the SoC testbench.

VERILATOR ?= verilator
TOP       ?= tb_soc_system
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TESTS PASSED" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
